/* Makefile */
VERILATOR ?= verilator
TOP       ?= isolde_exec_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) common/isolde_exec_settings.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/isolde_exec_pkg.sv */
// isolde execution stage types
`include "isolde_exec_settings.svh"

package isolde_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] xaddr_t;
  typedef logic [2:0] vaddr_t;
  typedef word_t [`ISOLDE_VLEN-1:0] vreg_t;

  typedef enum logic [2:0] {
    isolde_opcode_nop,
    isolde_opcode_r_type,
    isolde_opcode_redmule,
    isolde_opcode_redmule_gemm,
    isolde_opcode_redmule_gemm1,
    isolde_opcode_gemm,
    isolde_opcode_conv2d
  } isolde_opcode_e;

  typedef enum logic [2:0] {
    exec_idle,
    exec_start,
    exec_wait_local,
    exec_issue,
    exec_done
  } exec_state_e;

  typedef struct packed {
    isolde_opcode_e opcode;
    instr_t         instr;
    xaddr_t         xa;
    xaddr_t         xb;
    xaddr_t         xc;
    vaddr_t         va;
    word_t [2:0]    imm32;
    logic [2:0]     imm32_valid;
  } exec_req_t;

  typedef struct packed {
    instr_t      instr;
    word_t [2:0] rs;
    logic [2:0]  rs_valid;
    word_t [2:0] imm32;
    logic [2:0]  imm32_valid;
  } issue_req_t;

  typedef struct packed {
    logic   en;
    xaddr_t addr;
    word_t  data;
  } xreg_wr_t;

  typedef struct packed {
    logic   en;
    vaddr_t addr;
    vreg_t  data;
  } vreg_wr_t;

endpackage

/* common/isolde_exec_settings.svh */
// isolde execution stage constants
`ifndef ISOLDE_EXEC_SETTINGS_SVH
`define ISOLDE_EXEC_SETTINGS_SVH

// scalar register count, x0 included
`define ISOLDE_XREG_NUM 32

// vector registers and their length in 32-bit elements
`define ISOLDE_VREG_NUM 8
`define ISOLDE_VLEN 4

// retire latency of gemm and conv2d
`define ISOLDE_LOCAL_CYCLES 4

// fixed coprocessor word sent for redmule_gemm1
`define ISOLDE_REDMULE_INSTR 32'h087332ff

`endif

/* isolde_exec/isolde_exec_ctrl.sv */
// isolde execution control FSM
`timescale 1ns/1ps
`include "isolde_exec_settings.svh"

module isolde_exec_ctrl
  import isolde_exec_pkg::*;
(
  input  logic      clk,
  input  logic      g_rst_n,
  input  logic      exec_req,
  input  exec_req_t exec_req_data,
  output logic      exec_gnt,
  output logic      exec_dne,
  output logic      busy,
  output exec_req_t cur_req,
  output logic      issue_load,
  input  logic      issue_done
);

  localparam int cnt_w = $clog2(`ISOLDE_LOCAL_CYCLES) + 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`ISOLDE_LOCAL_CYCLES - 1);

  exec_state_e state, state_nxt;
  logic [cnt_w-1:0] cnt;
  logic is_timed;
  logic is_issue;

  // opcode class of the latched request
  always_comb begin
    is_timed = 1'b0;
    is_issue = 1'b0;
    case (cur_req.opcode)
      isolde_opcode_gemm,
      isolde_opcode_conv2d: is_timed = 1'b1;
      isolde_opcode_r_type,
      isolde_opcode_redmule,
      isolde_opcode_redmule_gemm,
      isolde_opcode_redmule_gemm1: is_issue = 1'b1;
      default: ; // nop and unknown retire at once
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      exec_idle: begin
        if (exec_req) state_nxt = exec_start;
      end
      exec_start: begin
        if (is_issue) state_nxt = exec_issue;
        else if (is_timed) state_nxt = exec_wait_local;
        else state_nxt = exec_done;
      end
      exec_wait_local: begin
        if (cnt == cnt_last) state_nxt = exec_done;
      end
      exec_issue: begin
        if (issue_done) state_nxt = exec_done; // accepted by coprocessor
      end
      exec_done: state_nxt = exec_idle;
      default: state_nxt = exec_idle;
    endcase
  end

  always_ff @(posedge clk or negedge g_rst_n) begin
    if (!g_rst_n) begin
      state <= exec_idle;
      cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == exec_start) begin
        cnt <= '0;
      end else if (state == exec_wait_local) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // request captured on the grant edge
  always_ff @(posedge clk) begin
    if (exec_gnt) begin
      cur_req <= exec_req_data;
    end
  end

  assign exec_gnt = (state == exec_idle) && exec_req;
  assign exec_dne = (state == exec_done);
  assign busy = exec_gnt || (state != exec_idle); // grant cycle through done
  assign issue_load = (state == exec_start) && is_issue;

endmodule

/* isolde_exec/isolde_issue_builder.sv */
// coprocessor issue register
`timescale 1ns/1ps
`include "isolde_exec_settings.svh"

module isolde_issue_builder
  import isolde_exec_pkg::*;
(
  input  logic       clk,
  input  logic       g_rst_n,
  input  logic       issue_load,
  input  exec_req_t  cur_req,
  input  word_t      xa_data,
  input  word_t      xb_data,
  input  word_t      xc_data,
  input  vreg_t      va_data,
  output logic       issue_valid,
  output issue_req_t issue_data,
  input  logic       issue_ready,
  output logic       issue_done
);

  issue_req_t issue_nxt;

  always_comb begin
    issue_nxt.instr = cur_req.instr;
    issue_nxt.rs = {xc_data, xb_data, xa_data}; // rs[0] is x[xa]
    issue_nxt.rs_valid = 3'b111;
    issue_nxt.imm32 = '0;
    issue_nxt.imm32_valid = 3'b000;
    case (cur_req.opcode)
      isolde_opcode_r_type: begin
        issue_nxt.rs = {xa_data, xc_data, xb_data}; // rd value goes last
      end
      isolde_opcode_redmule_gemm: begin
        issue_nxt.imm32 = cur_req.imm32;
        issue_nxt.imm32_valid = cur_req.imm32_valid;
      end
      isolde_opcode_redmule_gemm1: begin
        issue_nxt.instr = `ISOLDE_REDMULE_INSTR;
        issue_nxt.imm32 = {va_data[3], va_data[2], va_data[1]}; // element 0 unused
        issue_nxt.imm32_valid = 3'b111;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge g_rst_n) begin
    if (!g_rst_n) begin
      issue_valid <= 1'b0;
    end else if (issue_load) begin
      issue_valid <= 1'b1;
    end else if (issue_done) begin
      issue_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_load) begin
      issue_data <= issue_nxt;
    end
  end

  assign issue_done = issue_valid && issue_ready;

endmodule

/* sim.f */
+incdir+common
common/isolde_exec_pkg.sv
verilog/isolde_x_regfile.sv
verilog/isolde_vec_regfile.sv
isolde_exec/isolde_exec_ctrl.sv
isolde_exec/isolde_issue_builder.sv
verilog/isolde_exec_top.sv
testbench/isolde_exec_asserts.sv
testbench/isolde_exec_tb.sv

/* testbench/isolde_exec_asserts.sv */
// isolde handshake assertions
`timescale 1ns/1ps

module isolde_exec_asserts
  import isolde_exec_pkg::*;
(
  input logic       clk,
  input logic       g_rst_n,
  input logic       exec_req,
  input logic       exec_gnt,
  input logic       exec_dne,
  input logic       busy,
  input logic       issue_valid,
  input logic       issue_ready,
  input issue_req_t issue_data
);

  issue_hold: assert property (@(posedge clk) disable iff (!g_rst_n)
    issue_valid && !issue_ready |=> issue_valid && $stable(issue_data))
    else $error("issue_data or issue_valid changed before ready");

  // requester lets go of exec_req once granted
  gnt_needs_req: assert property (@(posedge clk) disable iff (!g_rst_n)
    exec_gnt |-> exec_req ##1 !exec_req)
    else $error("exec_gnt without exec_req or exec_req held after grant");

  dne_pulse: assert property (@(posedge clk) disable iff (!g_rst_n)
    exec_dne |=> !exec_dne)
    else $error("exec_dne longer than one cycle");

  // last busy cycle is the done cycle
  no_gnt_busy: assert property (@(posedge clk) disable iff (!g_rst_n)
    busy && !exec_dne |=> !exec_gnt)
    else $error("grant while busy");

endmodule

bind isolde_exec_top isolde_exec_asserts isolde_exec_asserts_inst (
  .clk         (clk),
  .g_rst_n     (g_rst_n),
  .exec_req    (exec_req),
  .exec_gnt    (exec_gnt),
  .exec_dne    (exec_dne),
  .busy        (busy),
  .issue_valid (issue_valid),
  .issue_ready (issue_ready),
  .issue_data  (issue_data)
);

/* testbench/isolde_exec_tb.sv */
// isolde execution stage testbench
`timescale 1ns/1ps
`include "isolde_exec_settings.svh"

module isolde_exec_tb
  import isolde_exec_pkg::*;
();

  logic clk;
  logic g_rst_n;
  logic exec_req;
  exec_req_t exec_req_data;
  logic exec_gnt;
  logic exec_dne;
  logic busy;
  xreg_wr_t xreg_wr;
  vreg_wr_t vreg_wr;
  logic issue_valid;
  issue_req_t issue_data;
  logic issue_ready;
  logic bp_on;
  int err_cnt;
  string test_name;
  word_t x_mirror [`ISOLDE_XREG_NUM];
  vreg_t v_mirror [`ISOLDE_VREG_NUM];
  issue_req_t exp_q [$];

  isolde_exec_top isolde_exec_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s %s expected %h actual %h", test_name, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic abort_run(input string why);
    err_cnt++;
    $display("%s: %s", test_name, why);
    stop_on_error();
  endtask

  // expected issue packet from the mirror
  function automatic issue_req_t ref_issue(input exec_req_t r);
    issue_req_t e;
    vreg_t v;
    v = v_mirror[r.va];
    e.instr = r.instr;
    e.rs[0] = x_mirror[r.xa];
    e.rs[1] = x_mirror[r.xb];
    e.rs[2] = x_mirror[r.xc];
    e.rs_valid = 3'b111;
    e.imm32 = '0;
    e.imm32_valid = 3'b000;
    if (r.opcode == isolde_opcode_r_type) begin
      e.rs[0] = x_mirror[r.xb];
      e.rs[1] = x_mirror[r.xc];
      e.rs[2] = x_mirror[r.xa]; // rd last
    end else if (r.opcode == isolde_opcode_redmule_gemm) begin
      e.imm32 = r.imm32;
      e.imm32_valid = r.imm32_valid;
    end else if (r.opcode == isolde_opcode_redmule_gemm1) begin
      e.instr = `ISOLDE_REDMULE_INSTR;
      e.imm32[0] = v[1];
      e.imm32[1] = v[2];
      e.imm32[2] = v[3];
      e.imm32_valid = 3'b111;
    end
    return e;
  endfunction

  function automatic exec_req_t make_req(input isolde_opcode_e op);
    exec_req_t r;
    r.opcode = op;
    r.instr = $urandom;
    r.xa = xaddr_t'($urandom);
    r.xb = xaddr_t'($urandom);
    r.xc = xaddr_t'($urandom);
    r.va = vaddr_t'($urandom);
    for (int k = 0; k < 3; k++) begin
      r.imm32[k] = $urandom;
    end
    r.imm32_valid = 3'($urandom);
    return r;
  endfunction

  task automatic load_regs();
    word_t d;
    vreg_t v;
    for (int i = 0; i < `ISOLDE_XREG_NUM; i++) begin
      d = $urandom;
      @(posedge clk);
      #2;
      xreg_wr = '{1'b1, xaddr_t'(i), d};
      x_mirror[i] = (i == 0) ? word_t'(0) : d; // x0 write is dropped
    end
    for (int j = 0; j < `ISOLDE_VREG_NUM; j++) begin
      for (int k = 0; k < `ISOLDE_VLEN; k++) begin
        v[k] = $urandom;
      end
      @(posedge clk);
      #2;
      xreg_wr.en = 1'b0;
      vreg_wr = '{1'b1, vaddr_t'(j), v};
      v_mirror[j] = v;
    end
    @(posedge clk);
    #2;
    vreg_wr.en = 1'b0;
  endtask

  // one request from grant to done, cycles counted from the grant edge
  task automatic run_op(input exec_req_t r);
    int n;
    int acc;
    bit issued;
    issued = r.opcode inside {isolde_opcode_r_type, isolde_opcode_redmule,
                              isolde_opcode_redmule_gemm, isolde_opcode_redmule_gemm1};
    if (issued) exp_q.push_back(ref_issue(r));
    @(posedge clk);
    #2;
    exec_req = 1'b1;
    exec_req_data = r;
    n = 0;
    @(negedge clk);
    while (!exec_gnt) begin
      n++;
      if (n > 50) abort_run("request was never granted");
      @(negedge clk);
    end
    if (!busy) abort_run("busy low in the grant cycle");
    @(posedge clk);
    #2;
    exec_req = 1'b0;
    n = 1;
    acc = -1;
    @(negedge clk);
    while (!exec_dne) begin
      if (!busy) abort_run("busy dropped before exec_dne");
      if (!issued && issue_valid) abort_run("issue_valid raised for a local opcode");
      if (issue_valid && issue_ready) acc = n;
      n++;
      if (n > 200) abort_run("exec_dne never came");
      @(negedge clk);
    end
    check_val("busy at done", 1, busy);
    if (issued) begin
      check_val("done after accept", acc + 1, n);
    end else if (r.opcode == isolde_opcode_nop) begin
      check_val("nop latency", 2, n);
    end else begin
      check_val("local latency", 2 + `ISOLDE_LOCAL_CYCLES, n);
    end
  endtask

  // compares every accepted issue in order
  always @(negedge clk) begin : compare_issue
    issue_req_t exp_item;
    if (g_rst_n && issue_valid && issue_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("issue transfer with no request outstanding");
      end else begin
        exp_item = exp_q.pop_front();
        check_val("issue_data", 256'(exp_item), 256'(issue_data));
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      #2;
      issue_ready = bp_on ? 1'(($urandom & 3) != 0) : 1'b1;
    end
  end

  initial begin
    int seed;
    exec_req_t r;
    seed = $urandom(43223);
    g_rst_n = 1'b0;
    exec_req = 1'b0;
    exec_req_data = '0;
    xreg_wr = '0;
    vreg_wr = '0;
    issue_ready = 1'b1;
    bp_on = 1'b0;
    err_cnt = 0;
    test_name = "reset";
    repeat (3) @(posedge clk);
    #2;
    g_rst_n = 1'b1;
    @(negedge clk);
    check_val("gnt dne busy valid", '0, {exec_gnt, exec_dne, busy, issue_valid});
    test_name = "load";
    load_regs();
    test_name = "nop";
    run_op(make_req(isolde_opcode_nop));
    test_name = "gemm";
    run_op(make_req(isolde_opcode_gemm));
    test_name = "conv2d";
    run_op(make_req(isolde_opcode_conv2d));
    test_name = "r_type";
    r = make_req(isolde_opcode_r_type);
    run_op(r);
    r.xc = '0; // x0 reads zero
    run_op(r);
    test_name = "redmule";
    r = make_req(isolde_opcode_redmule);
    r.xa = '0;
    run_op(r);
    test_name = "redmule_gemm";
    run_op(make_req(isolde_opcode_redmule_gemm));
    test_name = "redmule_gemm1";
    for (int j = 0; j < `ISOLDE_VREG_NUM; j++) begin
      r = make_req(isolde_opcode_redmule_gemm1);
      r.va = vaddr_t'(j);
      run_op(r);
    end
    test_name = "random mix";
    bp_on = 1'b1;
    repeat (40) run_op(make_req(isolde_opcode_e'($urandom_range(6, 0))));
    bp_on = 1'b0;
    test_name = "end";
    check_val("pending issues", 0, exp_q.size());
    if (err_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* verilog/isolde_exec_top.sv */
// isolde execution stage top
`timescale 1ns/1ps

module isolde_exec_top
  import isolde_exec_pkg::*;
(
  input  logic       clk,
  input  logic       g_rst_n,
  input  logic       exec_req,
  input  exec_req_t  exec_req_data,
  output logic       exec_gnt,
  output logic       exec_dne,
  output logic       busy,
  input  xreg_wr_t   xreg_wr,
  input  vreg_wr_t   vreg_wr,
  output logic       issue_valid,
  output issue_req_t issue_data,
  input  logic       issue_ready
);

  exec_req_t cur_req;
  logic issue_load;
  logic issue_done;
  word_t xa_data;
  word_t xb_data;
  word_t xc_data;
  vreg_t va_data;

  isolde_exec_ctrl isolde_exec_ctrl_inst (
    .clk           (clk),
    .g_rst_n       (g_rst_n),
    .exec_req      (exec_req),
    .exec_req_data (exec_req_data),
    .exec_gnt      (exec_gnt),
    .exec_dne      (exec_dne),
    .busy          (busy),
    .cur_req       (cur_req),
    .issue_load    (issue_load),
    .issue_done    (issue_done)
  );

  isolde_issue_builder isolde_issue_builder_inst (
    .clk         (clk),
    .g_rst_n     (g_rst_n),
    .issue_load  (issue_load),
    .cur_req     (cur_req),
    .xa_data     (xa_data),
    .xb_data     (xb_data),
    .xc_data     (xc_data),
    .va_data     (va_data),
    .issue_valid (issue_valid),
    .issue_data  (issue_data),
    .issue_ready (issue_ready),
    .issue_done  (issue_done)
  );

  isolde_x_regfile isolde_x_regfile_inst (
    .clk     (clk),
    .g_rst_n (g_rst_n),
    .xreg_wr (xreg_wr),
    .raddr_a (cur_req.xa),
    .raddr_b (cur_req.xb),
    .raddr_c (cur_req.xc),
    .rdata_a (xa_data),
    .rdata_b (xb_data),
    .rdata_c (xc_data)
  );

  isolde_vec_regfile isolde_vec_regfile_inst (
    .clk     (clk),
    .g_rst_n (g_rst_n),
    .vreg_wr (vreg_wr),
    .raddr   (cur_req.va),
    .rdata   (va_data)
  );

endmodule

/* verilog/isolde_vec_regfile.sv */
// vector register file
`timescale 1ns/1ps
`include "isolde_exec_settings.svh"

module isolde_vec_regfile
  import isolde_exec_pkg::*;
(
  input  logic     clk,
  input  logic     g_rst_n,
  input  vreg_wr_t vreg_wr,
  input  vaddr_t   raddr,
  output vreg_t    rdata
);

  vreg_t regs [`ISOLDE_VREG_NUM];

  // whole register written at once
  always_ff @(posedge clk or negedge g_rst_n) begin
    if (!g_rst_n) begin
      for (int i = 0; i < `ISOLDE_VREG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (vreg_wr.en) begin
      regs[vreg_wr.addr] <= vreg_wr.data;
    end
  end

  assign rdata = regs[raddr]; // async read

endmodule

/* verilog/isolde_x_regfile.sv */
// scalar register file
`timescale 1ns/1ps
`include "isolde_exec_settings.svh"

module isolde_x_regfile
  import isolde_exec_pkg::*;
(
  input  logic     clk,
  input  logic     g_rst_n,
  input  xreg_wr_t xreg_wr,
  input  xaddr_t   raddr_a,
  input  xaddr_t   raddr_b,
  input  xaddr_t   raddr_c,
  output word_t    rdata_a,
  output word_t    rdata_b,
  output word_t    rdata_c
);

  word_t regs [`ISOLDE_XREG_NUM];

  always_ff @(posedge clk or negedge g_rst_n) begin
    if (!g_rst_n) begin
      for (int i = 0; i < `ISOLDE_XREG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (xreg_wr.en && (xreg_wr.addr != '0)) begin
      regs[xreg_wr.addr] <= xreg_wr.data; // x0 never written
    end
  end

  function automatic word_t rd(input xaddr_t addr);
    return (addr == '0) ? word_t'(0) : regs[addr];
  endfunction

  assign rdata_a = rd(raddr_a);
  assign rdata_b = rd(raddr_b);
  assign rdata_c = rd(raddr_c);

endmodule
